// File: common/uart_pkg.sv
package uart_pkg;

	// frame layout
	localparam int data_bits  = 8;              // payload bits, lsb first
	localparam int oversample = 16;             // sample ticks per bit

	// sample points inside one bit
	localparam int vote_first = 7;              // votes at 7, 8, 9
	localparam int vote_calc  = vote_first + 3; // majority registered here
	localparam int vote_use   = vote_first + 4; // decision on the voted bit
	localparam int stop_valid = vote_use + 1;   // frame strobe in stop bit
	localparam int stop_done  = vote_use + 2;   // return to idle
	localparam int samp_last  = oversample - 1;

	localparam int samp_w     = $clog2(oversample);
	localparam int bit_w      = $clog2(data_bits);

	// channels and shared buffer
	localparam int n_chan     = 2;
	localparam int chan_w     = 1;
	localparam int buf_depth  = 8;              // frame entries
	localparam int ptr_w      = $clog2(buf_depth);
	localparam int occ_w      = $clog2(buf_depth + 1); // holds 0..buf_depth

	// baud divisor
	localparam int div_w      = 16;

	// receiver fsm
	typedef enum logic [1:0] {
		rx_idle   = 2'b00, // hunting for a start bit
		rx_data   = 2'b01,
		rx_parity = 2'b10,
		rx_stop   = 2'b11  // also waits for a high line after a bad stop
	} rx_state_t;

endpackage

// File: verilog/baud_tick_gen.sv
module baud_tick_gen import uart_pkg::*; (
	input  logic             mclk,
	input  logic             rst_n,
	input  logic [div_w-1:0] baud_div,
	output logic             sample_tick
);

	logic [div_w-1:0] cnt;

	// reload on zero, so the period is baud_div + 1 cycles
	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			cnt <= baud_div;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign sample_tick = (cnt == '0); // every cycle when baud_div is 0

endmodule

// File: uart_rx/uart_rx.sv
module uart_rx import uart_pkg::*; (
	input  logic                 mclk,
	input  logic                 rst_n,
	input  logic                 sample_tick,
	input  logic                 rxd,
	input  logic                 parity_en,
	input  logic                 parity_odd,
	output logic                 frame_valid,
	output logic [data_bits-1:0] frame_data,
	output logic                 frame_perr
);

	rx_state_t         state;
	logic [samp_w-1:0] sample_cnt; // tick index inside the current bit
	logic [bit_w-1:0]  bit_cnt;
	logic              rxd_meta;
	logic              rxd_s;
	logic [2:0]        samp;       // the three voting samples
	logic              vote;
	logic              stop_bad;   // bad stop seen, waiting for a high line

	// two-flop synchronizer, line idles high
	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_s    <= rxd_meta;
		end
	end

	// samples 7, 8, 9 and the majority, taken in every state
	always_ff @(posedge mclk) begin
		if (sample_tick) begin
			if (sample_cnt == samp_w'(vote_first))
				samp[0] <= rxd_s;
			if (sample_cnt == samp_w'(vote_first + 1))
				samp[1] <= rxd_s;
			if (sample_cnt == samp_w'(vote_first + 2))
				samp[2] <= rxd_s;
			if (sample_cnt == samp_w'(vote_calc))
				vote <= (samp[0] & samp[1]) | (samp[0] & samp[2]) | (samp[1] & samp[2]);
		end
	end

	// data shift register, lsb arrives first
	always_ff @(posedge mclk) begin
		if (sample_tick && state == rx_data && sample_cnt == samp_w'(vote_use))
			frame_data <= {vote, frame_data[data_bits-1:1]};
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= rx_idle;
			sample_cnt  <= '0;
			bit_cnt     <= '0;
			stop_bad    <= 1'b0;
			frame_perr  <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0; // one mclk strobe
			if (sample_tick) begin
				sample_cnt <= sample_cnt + 1'b1; // wraps after the last sample
				case (state)
					rx_idle: begin
						if (sample_cnt == '0 && rxd_s) begin
							sample_cnt <= '0; // line high, keep hunting
						end else if (sample_cnt == samp_w'(vote_use) && vote) begin
							sample_cnt <= '0; // glitch, not a start bit
						end else if (sample_cnt == samp_w'(samp_last)) begin
							state      <= rx_data;
							bit_cnt    <= '0;
							frame_perr <= 1'b0;
						end
					end
					rx_data: begin
						if (sample_cnt == samp_w'(samp_last)) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == bit_w'(data_bits - 1))
								state <= parity_en ? rx_parity : rx_stop;
						end
					end
					rx_parity: begin
						if (sample_cnt == samp_w'(vote_use))
							frame_perr <= vote ^ (^frame_data) ^ parity_odd;
						if (sample_cnt == samp_w'(samp_last))
							state <= rx_stop;
					end
					rx_stop: begin
						if (stop_bad) begin
							sample_cnt <= '0;
							if (rxd_s) begin
								stop_bad <= 1'b0;
								state    <= rx_idle;
							end
						end else if (sample_cnt == samp_w'(vote_use) && !vote) begin
							stop_bad   <= 1'b1; // framing error, frame dropped
							sample_cnt <= '0;
						end else if (sample_cnt == samp_w'(stop_valid)) begin
							frame_valid <= 1'b1;
						end else if (sample_cnt == samp_w'(stop_done)) begin
							sample_cnt <= '0;
							state      <= rx_idle;
						end
					end
					default: state <= rx_idle;
				endcase
			end
		end
	end

	// the strobe is only raised from the stop bit and dropped before leaving it
	a_valid_in_stop: assert property (@(posedge mclk) disable iff (!rst_n)
		frame_valid |-> state == rx_stop);

endmodule

// File: verilog/rx_arbiter.sv
module rx_arbiter import uart_pkg::*; (
	input  logic                 mclk,
	input  logic                 rst_n,
	input  logic                 req0_valid,
	input  logic [data_bits-1:0] req0_data,
	input  logic                 req0_perr,
	input  logic                 req1_valid,
	input  logic [data_bits-1:0] req1_data,
	input  logic                 req1_perr,
	output logic                 wr_en,
	output logic [data_bits-1:0] wr_data,
	output logic                 wr_perr,
	output logic [chan_w-1:0]    wr_chan
);

	logic [n_chan-1:0]    req_v;
	logic [data_bits-1:0] req_d [n_chan];
	logic [n_chan-1:0]    req_p;
	logic [n_chan-1:0]    pend_v;
	logic [data_bits-1:0] pend_d [n_chan];
	logic [n_chan-1:0]    pend_p;
	logic [chan_w-1:0]    last_grant;
	logic [chan_w-1:0]    grant;

	assign req_v    = {req1_valid, req0_valid};
	assign req_p    = {req1_perr, req0_perr};
	assign req_d[0] = req0_data;
	assign req_d[1] = req1_data;

	// with both waiting the one not served last goes first
	always_comb begin
		if (&pend_v)
			grant = ~last_grant;
		else
			grant = chan_w'(pend_v[1]);
	end

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			pend_v     <= '0;
			last_grant <= chan_w'(n_chan - 1); // channel 0 wins first
		end else begin
			for (int i = 0; i < n_chan; i++) begin
				if (req_v[i])
					pend_v[i] <= 1'b1;
				else if (wr_en && grant == chan_w'(i))
					pend_v[i] <= 1'b0;
			end
			if (wr_en)
				last_grant <= grant;
		end
	end

	always_ff @(posedge mclk) begin
		for (int i = 0; i < n_chan; i++) begin
			if (req_v[i]) begin
				pend_d[i] <= req_d[i];
				pend_p[i] <= req_p[i];
			end
		end
	end

	assign wr_en   = |pend_v;
	assign wr_chan = grant;
	assign wr_data = pend_d[grant];
	assign wr_perr = pend_p[grant];

	// a receiver never finishes a second frame before its first is written
	for (genvar g = 0; g < n_chan; g++) begin : g_chk
		a_no_overrun: assert property (@(posedge mclk) disable iff (!rst_n)
			req_v[g] |-> !pend_v[g]);
	end

	// of two waiting entries the other channel is written on the next cycle
	a_pair_served: assert property (@(posedge mclk) disable iff (!rst_n)
		&pend_v |=> wr_en && wr_chan != $past(wr_chan));

endmodule

// File: verilog/rx_buffer.sv
module rx_buffer import uart_pkg::*; (
	input  logic                 mclk,
	input  logic                 rst_n,
	input  logic                 wr_en,
	input  logic [data_bits-1:0] wr_data,
	input  logic                 wr_perr,
	input  logic [chan_w-1:0]    wr_chan,
	input  logic                 rd_en,
	output logic [data_bits-1:0] rd_data,
	output logic                 rd_perr,
	output logic [chan_w-1:0]    rd_chan,
	output logic                 buf_empty,
	output logic                 overflow
);

	logic [data_bits-1:0] mem_data [buf_depth];
	logic                 mem_perr [buf_depth];
	logic [chan_w-1:0]    mem_chan [buf_depth];
	logic [ptr_w-1:0]     wr_ptr;
	logic [ptr_w-1:0]     rd_ptr;
	logic [occ_w-1:0]     count;
	logic                 full;
	logic                 push;
	logic                 pop;

	assign full      = (count == occ_w'(buf_depth));
	assign buf_empty = (count == '0);
	assign push      = wr_en && !full; // full drops the frame
	assign pop       = rd_en && !buf_empty;

	always_ff @(posedge mclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr_en && full)
				overflow <= 1'b1; // sticky until reset
		end
	end

	always_ff @(posedge mclk) begin
		if (push) begin
			mem_data[wr_ptr] <= wr_data;
			mem_perr[wr_ptr] <= wr_perr;
			mem_chan[wr_ptr] <= wr_chan;
		end
	end

	// show-ahead, head entry always on the read port
	assign rd_data = mem_data[rd_ptr];
	assign rd_perr = mem_perr[rd_ptr];
	assign rd_chan = mem_chan[rd_ptr];

	a_count_max: assert property (@(posedge mclk) disable iff (!rst_n)
		count <= occ_w'(buf_depth));

endmodule

// File: verilog/uart_dual_rx.sv
module uart_dual_rx import uart_pkg::*; (
	input  logic                 mclk,
	input  logic                 rst_n,
	input  logic [div_w-1:0]     baud_div,
	input  logic                 parity_en,
	input  logic                 parity_odd,
	input  logic                 rxd0,
	input  logic                 rxd1,
	input  logic                 rd_en,
	output logic [data_bits-1:0] rd_data,
	output logic                 rd_perr,
	output logic [chan_w-1:0]    rd_chan,
	output logic                 buf_empty,
	output logic                 overflow
);

	logic                 sample_tick;
	logic [n_chan-1:0]    frame_valid;
	logic [n_chan-1:0]    frame_perr;
	logic [data_bits-1:0] frame_data [n_chan];
	logic                 wr_en;
	logic [data_bits-1:0] wr_data;
	logic                 wr_perr;
	logic [chan_w-1:0]    wr_chan;

	baud_tick_gen u_tick (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.baud_div    (baud_div),
		.sample_tick (sample_tick)
	);

	uart_rx u_rx0 (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.sample_tick (sample_tick),
		.rxd         (rxd0),
		.parity_en   (parity_en),
		.parity_odd  (parity_odd),
		.frame_valid (frame_valid[0]),
		.frame_data  (frame_data[0]),
		.frame_perr  (frame_perr[0])
	);

	uart_rx u_rx1 (
		.mclk        (mclk),
		.rst_n       (rst_n),
		.sample_tick (sample_tick),
		.rxd         (rxd1),
		.parity_en   (parity_en),
		.parity_odd  (parity_odd),
		.frame_valid (frame_valid[1]),
		.frame_data  (frame_data[1]),
		.frame_perr  (frame_perr[1])
	);

	rx_arbiter u_arb (
		.mclk       (mclk),
		.rst_n      (rst_n),
		.req0_valid (frame_valid[0]),
		.req0_data  (frame_data[0]),
		.req0_perr  (frame_perr[0]),
		.req1_valid (frame_valid[1]),
		.req1_data  (frame_data[1]),
		.req1_perr  (frame_perr[1]),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.wr_perr    (wr_perr),
		.wr_chan    (wr_chan)
	);

	rx_buffer u_buf (
		.mclk      (mclk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.wr_perr   (wr_perr),
		.wr_chan   (wr_chan),
		.rd_en     (rd_en),
		.rd_data   (rd_data),
		.rd_perr   (rd_perr),
		.rd_chan   (rd_chan),
		.buf_empty (buf_empty),
		.overflow  (overflow)
	);

endmodule

// File: tb/tb_uart_dual_rx.sv
module tb_uart_dual_rx import uart_pkg::*; ();

	localparam int clk_period = 8;
	localparam int div_val    = 3;
	localparam int tick_cyc   = div_val + 1;
	localparam int bit_cyc    = oversample * tick_cyc; // mclk cycles per bit
	localparam int n_rows     = 14;
	localparam int wd_time    = (n_rows + 12) * 12 * bit_cyc * clk_period;
	localparam int wait_max   = 2 * bit_cyc;
	localparam logic [7:0] no_glitch = 8'hff;

	typedef struct packed {
		logic [data_bits-1:0] d0;
		logic [data_bits-1:0] d1;
		logic [1:0]           chans;    // bit n sends on rxd n
		logic                 par_en;
		logic                 par_odd;
		logic                 bad_par;
		logic                 bad_stop;
		logic [7:0]           glitch;   // frame sample index to flip
	} row_t;

	logic                 mclk;
	logic                 rst_n;
	logic [div_w-1:0]     baud_div;
	logic                 parity_en;
	logic                 parity_odd;
	logic                 rxd0;
	logic                 rxd1;
	logic                 rd_en;
	logic [data_bits-1:0] rd_data;
	logic                 rd_perr;
	logic [chan_w-1:0]    rd_chan;
	logic                 buf_empty;
	logic                 overflow;

	row_t                 rows [n_rows];
	logic [data_bits+1:0] exp_q [$];  // {chan, perr, data}
	logic                 last_grant;
	integer               seed = 32'ha70e_0c60;
	int                   val_errs = 0;
	int                   other_errs = 0;

	uart_dual_rx i_uart_dual_rx (.*);

	initial begin
		mclk = 1'b0;
		forever #(clk_period / 2) mclk = ~mclk;
	end

	task automatic fill_table();
		rows[0]  = '{8'($random(seed)), 8'($random(seed)), 2'b11, 1'b0, 1'b0, 1'b0, 1'b0, no_glitch};
		rows[1]  = '{8'h5a, 8'h00, 2'b01, 1'b0, 1'b0, 1'b0, 1'b0, no_glitch};
		rows[2]  = '{8'h00, 8'hc3, 2'b10, 1'b0, 1'b0, 1'b0, 1'b0, no_glitch};
		rows[3]  = '{8'($random(seed)), 8'h00, 2'b01, 1'b1, 1'b0, 1'b0, 1'b0, no_glitch};
		rows[4]  = '{8'($random(seed)), 8'h00, 2'b01, 1'b1, 1'b0, 1'b1, 1'b0, no_glitch};
		rows[5]  = '{8'h00, 8'($random(seed)), 2'b10, 1'b1, 1'b1, 1'b0, 1'b0, no_glitch};
		rows[6]  = '{8'h00, 8'($random(seed)), 2'b10, 1'b1, 1'b1, 1'b1, 1'b0, no_glitch};
		rows[7]  = '{8'hb6, 8'h00, 2'b01, 1'b0, 1'b0, 1'b0, 1'b0, 8'd72}; // data bit 3, sample 8
		rows[8]  = '{8'($random(seed)), 8'($random(seed)), 2'b11, 1'b1, 1'b1, 1'b0, 1'b0, no_glitch};
		rows[9]  = '{8'h00, 8'h00, 2'b00, 1'b0, 1'b0, 1'b0, 1'b0, no_glitch}; // lone pulse
		rows[10] = '{8'h00, 8'($random(seed)), 2'b10, 1'b0, 1'b0, 1'b0, 1'b1, no_glitch};
		rows[11] = '{8'h00, 8'($random(seed)), 2'b10, 1'b0, 1'b0, 1'b0, 1'b0, no_glitch};
		rows[12] = '{8'($random(seed)), 8'h00, 2'b01, 1'b1, 1'b0, 1'b0, 1'b1, no_glitch};
		rows[13] = '{8'($random(seed)), 8'h00, 2'b01, 1'b1, 1'b0, 1'b0, 1'b0, no_glitch};
	endtask

	task automatic drive_line(input int chan, input logic v);
		if (chan == 0)
			rxd0 = v;
		else
			rxd1 = v;
	endtask

	// start, 8 data bits lsb first, optional parity and stop
	task automatic send_frame(input int chan, input logic [7:0] data, input logic par_en,
			input logic par_odd, input logic bad_par, input logic stop_val, input int glitch_at);
		logic [10:0] bits;
		int          n_bits;
		logic        v;
		if (par_en) begin
			bits   = {stop_val, ^data ^ par_odd ^ bad_par, data, 1'b0};
			n_bits = 11;
		end else begin
			bits   = {1'b1, stop_val, data, 1'b0};
			n_bits = 10;
		end
		for (int t = 0; t < n_bits * oversample; t++) begin
			v = bits[4'(t / oversample)]; // one line value per tick
			if (t == glitch_at)
				v = ~v;
			drive_line(chan, v);
			repeat (tick_cyc) @(posedge mclk);
			#1;
		end
		drive_line(chan, 1'b1);
	endtask

	task automatic run_row(input row_t r);
		parity_en  = r.par_en;
		parity_odd = r.par_odd;
		if (r.chans == 2'b00) begin
			rxd0 = 1'b0; // single tick low on an idle line
			repeat (tick_cyc) @(posedge mclk);
			#1;
			rxd0 = 1'b1;
			// a taken start bit would have delivered its frame by now
			repeat ((oversample * (9 + int'(r.par_en)) + 12) * tick_cyc) @(posedge mclk);
			#1;
		end else begin
			fork
				if (r.chans[0])
					send_frame(0, r.d0, r.par_en, r.par_odd, r.bad_par, !r.bad_stop, int'(r.glitch));
				if (r.chans[1])
					send_frame(1, r.d1, r.par_en, r.par_odd, r.bad_par, !r.bad_stop, int'(r.glitch));
			join
		end
	endtask

	// entries a row should leave in the buffer
	task automatic expect_row(input row_t r);
		logic perr;
		logic first;
		perr = r.par_en & r.bad_par;
		if (!r.bad_stop && r.chans != 2'b00) begin
			first = (r.chans == 2'b11) ? ~last_grant : r.chans[1]; // ties go to the one not served last
			exp_q.push_back({first, perr, first ? r.d1 : r.d0});
			last_grant = first;
			if (r.chans == 2'b11) begin
				exp_q.push_back({~first, perr, first ? r.d0 : r.d1});
				last_grant = ~first;
			end
		end
	endtask

	task automatic pop_entry();
		rd_en = 1'b1;
		@(posedge mclk);
		#1;
		rd_en = 1'b0;
	endtask

	task automatic drain_and_check();
		logic [data_bits+1:0] e;
		int                   waited;
		while (exp_q.size() > 0) begin
			e      = exp_q.pop_front();
			waited = 0;
			while (buf_empty && waited < wait_max) begin
				@(posedge mclk);
				#1;
				waited++;
			end
			assert (!buf_empty) else begin
				other_errs++;
				$display("Frame %h from channel %0d never reached the buffer by %0t",
					e[data_bits-1:0], e[data_bits+1], $time);
			end
			if (!buf_empty) begin
				assert (rd_data === e[data_bits-1:0]) else begin
					val_errs++;
					$display("Error at %0t: rd_data = %h, expected %h", $time, rd_data,
						e[data_bits-1:0]);
				end
				assert (rd_perr === e[data_bits]) else begin
					val_errs++;
					$display("Error at %0t: rd_perr = %b, expected %b", $time, rd_perr, e[data_bits]);
				end
				assert (rd_chan === e[data_bits+1]) else begin
					val_errs++;
					$display("Error at %0t: rd_chan = %0d, expected %0d", $time, rd_chan,
						e[data_bits+1]);
				end
				pop_entry();
			end
		end
		repeat (4) @(posedge mclk);
		#1;
		assert (buf_empty) else begin
			other_errs++;
			$display("Unexpected frame %h from channel %0d in the buffer at %0t",
				rd_data, rd_chan, $time);
		end
		for (int k = 0; k < buf_depth && !buf_empty; k++)
			pop_entry();
	endtask

	initial begin
		row_t r;
		rst_n      = 1'b0;
		baud_div   = div_w'(div_val);
		parity_en  = 1'b0;
		parity_odd = 1'b0;
		rxd0       = 1'b1;
		rxd1       = 1'b1;
		rd_en      = 1'b0;
		last_grant = 1'b1; // channel 0 takes the first tie
		fill_table();
		repeat (5) @(posedge mclk);
		#1;
		rst_n = 1'b1;
		assert (buf_empty && !overflow) else begin
			other_errs++;
			$display("Buffer not empty or overflow set right after reset");
		end
		for (int i = 0; i < n_rows; i++) begin
			expect_row(rows[i]);
			run_row(rows[i]);
			repeat (2 * bit_cyc) @(posedge mclk);
			#1;
			drain_and_check();
			assert (!overflow) else begin
				other_errs++;
				$display("Overflow set after row %0d with a nearly empty buffer", i);
			end
		end
		// two frames more than the buffer holds and no reads in between
		for (int k = 0; k < buf_depth + 2; k++) begin
			r = '{8'($random(seed)), 8'h00, 2'b01, 1'b0, 1'b0, 1'b0, 1'b0, no_glitch};
			if (k < buf_depth)
				expect_row(r);
			run_row(r);
			repeat (bit_cyc) @(posedge mclk);
			#1;
		end
		assert (overflow) else begin
			other_errs++;
			$display("Overflow not set after %0d frames into a full buffer", buf_depth + 2);
		end
		drain_and_check();
		$display("End of run: %0d value errors, %0d other errors", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin : watchdog
		rx_state_t st0;
		rx_state_t st1;
		#(wd_time);
		st0 = i_uart_dual_rx.u_rx0.state;
		st1 = i_uart_dual_rx.u_rx1.state;
		$display("Run did not finish within %0d time units, receivers in %s and %s",
			wd_time, st0.name(), st1.name());
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: list.f
common/uart_pkg.sv
verilog/baud_tick_gen.sv
uart_rx/uart_rx.sv
verilog/rx_arbiter.sv
verilog/rx_buffer.sv
verilog/uart_dual_rx.sv
tb/tb_uart_dual_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module tb_uart_dual_rx -f list.f \
	&& ./obj_dir/Vtb_uart_dual_rx 2>&1 | tee sim.log \
	|| { echo "FAIL: build or simulation run aborted"; exit 1; }

! grep -q "Simulation failed" sim.log && grep -q "Simulation passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL: see sim.log"; exit 1; }
